// ==== files.f ====
+incdir+hw
+incdir+bench
hw/core_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/mips_pipe_top.sv
bench/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= core_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/core_model.svh ====
/*
 * in-order reference model of the core
 * runs the ROM program one instruction at a time on its own register
 * file and data memory copy, and lists the stores the bus must carry
 */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

logic [31:0] model_regs [0:31];
logic [31:0] model_mem  [0:MEM_WORDS-1];
// expected bus stores in program order
logic [29:0] exp_adr [$];
logic [3:0]  exp_sel [$];
logic [31:0] exp_dat [$];

// byte enables widened to a bit mask
function automatic logic [31:0] lane_mask(input logic [3:0] sel);
   return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
endfunction

// enabled lanes of nw replace those of old
function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] nw,
                                            input logic [3:0] sel);
   return (old & ~lane_mask(sel)) | (nw & lane_mask(sel));
endfunction

task automatic run_model();
   logic [31:0] w, a, b, se, ze, addr, lane, res, dat;
   logic [5:0]  op, fn;
   logic [4:0]  sh, dest, lsh;
   logic [3:0]  sel;
   logic        wr;
   for (int r = 0; r < 32; r++)
      model_regs[r] = '0;
   for (int i = 0; i < MEM_WORDS; i++)
      model_mem[i] = preset[i];
   for (int pc = 0; pc < PROG_LEN; pc++) begin
      w    = rom[pc];
      op   = w[31:26];
      fn   = w[5:0];
      sh   = w[10:6];
      a    = model_regs[w[25:21]];
      b    = model_regs[w[20:16]];
      se   = {{16{w[15]}}, w[15:0]};
      ze   = {16'h0, w[15:0]};
      addr = a + se;
      lsh  = {addr[1:0], 3'b000};
      lane = model_mem[addr[9:2]] >> lsh;
      dest = w[20:16];
      wr   = 1'b1;
      res  = '0;
      case (op)
         `CORE_OP_SPECIAL: begin
            dest = w[15:11];
            case (fn)
               `CORE_FN_SLL:  res = b << sh;
               `CORE_FN_SRL:  res = b >> sh;
               `CORE_FN_SRA:  res = $signed(b) >>> sh;
               `CORE_FN_SLLV: res = b << a[4:0];
               `CORE_FN_SRLV: res = b >> a[4:0];
               `CORE_FN_SRAV: res = $signed(b) >>> a[4:0];
               `CORE_FN_ADD, `CORE_FN_ADDU: res = a + b;
               `CORE_FN_SUB, `CORE_FN_SUBU: res = a - b;
               `CORE_FN_AND:  res = a & b;
               `CORE_FN_OR:   res = a | b;
               `CORE_FN_XOR:  res = a ^ b;
               `CORE_FN_NOR:  res = ~(a | b);
               `CORE_FN_SLT:  res = {31'h0, $signed(a) < $signed(b)};
               `CORE_FN_SLTU: res = {31'h0, a < b};
               default:       wr = 1'b0;
            endcase
         end
         `CORE_OP_ADDI, `CORE_OP_ADDIU: res = a + se;
         `CORE_OP_SLTI:  res = {31'h0, $signed(a) < $signed(se)};
         // sign extended immediate, compared unsigned
         `CORE_OP_SLTIU: res = {31'h0, a < se};
         `CORE_OP_ANDI:  res = a & ze;
         `CORE_OP_ORI:   res = a | ze;
         `CORE_OP_XORI:  res = a ^ ze;
         `CORE_OP_LUI:   res = {w[15:0], 16'h0};
         `CORE_OP_LB:    res = {{24{lane[7]}}, lane[7:0]};
         `CORE_OP_LH:    res = {{16{lane[15]}}, lane[15:0]};
         `CORE_OP_LW:    res = model_mem[addr[9:2]];
         `CORE_OP_LBU:   res = {24'h0, lane[7:0]};
         `CORE_OP_LHU:   res = {16'h0, lane[15:0]};
         `CORE_OP_SB, `CORE_OP_SH, `CORE_OP_SW: begin
            wr = 1'b0;
            if (op == `CORE_OP_SB) begin
               sel = 4'b0001 << addr[1:0];
               dat = {24'h0, b[7:0]} << lsh;
            end else if (op == `CORE_OP_SH) begin
               sel = 4'b0011 << addr[1:0];
               dat = {16'h0, b[15:0]} << lsh;
            end else begin
               sel = 4'b1111;
               dat = b;
            end
            model_mem[addr[9:2]] = merge_lanes(model_mem[addr[9:2]], dat, sel);
            exp_adr.push_back(addr[31:2]);
            exp_sel.push_back(sel);
            exp_dat.push_back(dat);
         end
         // unknown opcodes retire with no effect
         default: wr = 1'b0;
      endcase
      if (wr && dest != 5'd0)
         model_regs[dest] = res;
   end
endtask

`endif

// ==== bench/core_tb.sv ====
/*
 * testbench of the four-stage MIPS-I subset core
 * builds a random program from an LFSR, serves it from a ROM, answers
 * the Wishbone data port with random ack waits and compares every store
 * with an in-order model of the same program
 */
`timescale 1ns/100ps
`include "core_params.svh"

module core_tb;

   localparam int PROG_LEN       = 200;
   localparam int INIT_LEN       = 31;
   localparam int DUMP_LEN       = 31;
   localparam int ROM_WORDS      = 256;
   localparam int MEM_WORDS      = 256;
   localparam int N_WAITS        = 512;
   localparam int DUMP_BASE      = 'h300;
   localparam int TIMEOUT_CYCLES = 8 * PROG_LEN + 100;
   localparam logic [31:0] LFSR_SEED = 32'hd336;
   // x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   localparam logic [5:0] R_FUNCTS [16] = '{
      `CORE_FN_SLL, `CORE_FN_SRL, `CORE_FN_SRA, `CORE_FN_SLLV, `CORE_FN_SRLV, `CORE_FN_SRAV,
      `CORE_FN_ADD, `CORE_FN_ADDU, `CORE_FN_SUB, `CORE_FN_SUBU, `CORE_FN_AND, `CORE_FN_OR,
      `CORE_FN_XOR, `CORE_FN_NOR, `CORE_FN_SLT, `CORE_FN_SLTU};
   localparam logic [5:0] I_OPS [8] = '{
      `CORE_OP_ADDI, `CORE_OP_ADDIU, `CORE_OP_SLTI, `CORE_OP_SLTIU,
      `CORE_OP_ANDI, `CORE_OP_ORI, `CORE_OP_XORI, `CORE_OP_LUI};
   localparam logic [5:0] LD_OPS [5] = '{
      `CORE_OP_LB, `CORE_OP_LH, `CORE_OP_LW, `CORE_OP_LBU, `CORE_OP_LHU};
   localparam logic [5:0] ST_OPS [3] = '{`CORE_OP_SB, `CORE_OP_SH, `CORE_OP_SW};

   logic        clk;
   logic        rst_b;
   logic [29:0] inst_addr;
   logic [31:0] inst;
   logic        wb_cyc, wb_stb, wb_we, wb_ack;
   logic [29:0] wb_adr;
   logic [3:0]  wb_sel;
   logic [31:0] wb_dat_w, wb_dat_r;

   logic [31:0] lfsr;
   logic [31:0] rom    [0:ROM_WORDS-1];
   logic [31:0] preset [0:MEM_WORDS-1];
   logic [31:0] dmem   [0:MEM_WORDS-1];
   logic [1:0]  waits  [0:N_WAITS-1];
   logic [29:0] rom_idx;
   logic [8:0]  acc_idx;
   logic [1:0]  wait_left;
   logic        ack_ready = 1'b0;
   int          stores_seen;
   int          mismatches = 0;
   int          extra_stores = 0;
   int          cycles = 0;

   `include "core_model.svh"

   mips_pipe_top mips_pipe_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // instruction ROM, no-ops past the program
   assign rom_idx = inst_addr - 30'(`CORE_TEXT_START >> 2);
   assign inst    = (rom_idx < ROM_WORDS) ? rom[rom_idx[7:0]] : 32'h0;

   // slave answers at once from memory, ack only while stb is up
   assign wb_dat_r = dmem[wb_adr[7:0]];
   assign wb_ack   = wb_stb && ack_ready;

   // one output bit per step, shifted into the value
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
      return {`CORE_OP_SPECIAL, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // init all registers, random body on r0..r7, then dump r1..r31
   task automatic build_program();
      logic [3:0] kind;
      logic [4:0] rs, rt, rd;
      logic [5:0] op;
      logic [7:0] word;
      logic [1:0] off;
      for (int i = 0; i < ROM_WORDS; i++)
         rom[i] = 32'h0;
      for (int r = 1; r <= INIT_LEN; r++)
         rom[r - 1] = enc_i(`CORE_OP_ORI, 5'd0, 5'(r), 16'(rand_bits(16)));
      for (int p = INIT_LEN; p < PROG_LEN - DUMP_LEN; p++) begin
         kind = 4'(rand_bits(4));
         rs   = 5'(rand_bits(3));
         rt   = 5'(rand_bits(3));
         rd   = 5'(rand_bits(3));
         word = 8'(rand_bits(8));
         if (kind < 4'd6) begin
            rom[p] = enc_r(R_FUNCTS[rand_bits(4)], rs, rt, rd, 5'(rand_bits(5)));
         end else if (kind < 4'd10) begin
            rom[p] = enc_i(I_OPS[rand_bits(3)], rs, rt, 16'(rand_bits(16)));
         end else begin
            op  = (kind < 4'd13) ? LD_OPS[rand_bits(3) % 5] : ST_OPS[rand_bits(2) % 3];
            off = 2'(rand_bits(2));
            // natural alignment for halfwords and words
            if (op inside {`CORE_OP_LH, `CORE_OP_LHU, `CORE_OP_SH})
               off[0] = 1'b0;
            else if (op inside {`CORE_OP_LW, `CORE_OP_SW})
               off = 2'b00;
            rom[p] = enc_i(op, 5'd0, rt, {6'h0, word, off});
         end
      end
      for (int r = 1; r <= DUMP_LEN; r++)
         rom[PROG_LEN - DUMP_LEN + r - 1] = enc_i(`CORE_OP_SW, 5'd0, 5'(r),
                                                 16'(DUMP_BASE + 4 * r));
   endtask

   task automatic flag_mismatch(input string name, input int idx, input logic [31:0] exp,
                                input logic [31:0] act);
      mismatches++;
      $display("FAIL %s[%0d] expected %h actual %h", name, idx, exp, act);
   endtask

   // compare the store on the bus with the next one of the model
   task automatic check_store();
      int i;
      i = stores_seen;
      assert (i < exp_adr.size()) else begin
         extra_stores++;
         $display("store %0d to word %h was not expected by the model", i, wb_adr);
      end
      if (i < exp_adr.size()) begin
         assert (wb_adr == exp_adr[i]) else
            flag_mismatch("store_adr", i, 32'(exp_adr[i]), 32'(wb_adr));
         assert (wb_sel == exp_sel[i]) else
            flag_mismatch("store_sel", i, 32'(exp_sel[i]), 32'(wb_sel));
         assert ((wb_dat_w & lane_mask(wb_sel)) == exp_dat[i]) else
            flag_mismatch("store_data", i, exp_dat[i], wb_dat_w & lane_mask(wb_sel));
      end
   endtask

   // data memory, waits for the next access drawn when one completes
   always @(posedge clk) begin
      if (!rst_b) begin
         for (int i = 0; i < MEM_WORDS; i++)
            dmem[i] <= preset[i];
         acc_idx     <= '0;
         ack_ready   <= (waits[0] == 2'd0);
         wait_left   <= waits[0];
         stores_seen <= 0;
      end else if (wb_cyc && wb_stb && wb_ack) begin
         if (wb_we) begin
            check_store();
            dmem[wb_adr[7:0]] <= merge_lanes(dmem[wb_adr[7:0]], wb_dat_w, wb_sel);
            stores_seen       <= stores_seen + 1;
         end
         acc_idx   <= acc_idx + 9'd1;
         ack_ready <= (waits[acc_idx + 9'd1] == 2'd0);
         wait_left <= waits[acc_idx + 9'd1];
      end else if (wb_stb) begin
         ack_ready <= (wait_left == 2'd1);
         wait_left <= wait_left - 2'd1;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, %0d of %0d stores seen",
                  cycles, stores_seen, exp_adr.size());
         $display("Testbench failed");
         $finish;
      end
   end

   initial begin
      int missing;
      int reset_errors;
      missing      = 0;
      reset_errors = 0;
      rst_b        = 1'b0;
      lfsr         = LFSR_SEED;
      build_program();
      for (int i = 0; i < MEM_WORDS; i++)
         preset[i] = rand_bits(32);
      for (int i = 0; i < N_WAITS; i++)
         waits[i] = 2'(rand_bits(2) % 3);
      run_model();
      // bus idle and pc at the reset vector while reset is held
      repeat (8) begin
         @(negedge clk);
         assert (!wb_cyc && !wb_stb && !wb_we && wb_sel == 4'h0 &&
                 inst_addr == 30'(`CORE_TEXT_START >> 2)) else begin
            reset_errors++;
            $display("bus active or pc off the reset vector during reset");
         end
      end
      @(posedge clk);
      rst_b <= 1'b1;
      while (stores_seen < exp_adr.size())
         @(posedge clk);
      // room for a stray store after the last expected one
      repeat (20) @(posedge clk);
      assert (stores_seen == exp_adr.size()) else begin
         missing++;
         $display("saw %0d stores where the model made %0d", stores_seen, exp_adr.size());
      end
      $display("errors: %0d value mismatches, %0d extra stores, %0d count, %0d reset",
               mismatches, extra_stores, missing, reset_errors);
      if (mismatches + extra_stores + missing + reset_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== hw/mips_pipe_top.sv ====
/*
 * four-stage MIPS-I subset core
 * wires fetch, decode, execute and memory; a waiting bus access
 * freezes every pipeline register including the pc
 */
`timescale 1ns/100ps
`include "core_params.svh"

module mips_pipe_top import core_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_b,
   output logic [29:0]            inst_addr,
   input  logic [31:0]            inst,
   output logic                   wb_cyc,
   output logic                   wb_stb,
   output logic                   wb_we,
   output logic [29:0]            wb_adr,
   output logic [`CORE_SEL_W-1:0] wb_sel,
   output logic [`CORE_XLEN-1:0]  wb_dat_w,
   input  logic [`CORE_XLEN-1:0]  wb_dat_r,
   input  logic                   wb_ack
);

   // global freeze from the memory stage
   logic                   freeze;
   logic                   hazard_stall;
   instr_u                 id_inst;
   logic                   id_valid;
   // decode to execute
   logic [`CORE_XLEN-1:0]  ex_a, ex_b, ex_imm;
   logic [`CORE_RADDR-1:0] ex_rd;
   logic                   ex_we;
   alu_op_e                ex_alu_op;
   load_op_e               ex_load_op;
   store_op_e              ex_store_op;
   // execute to memory
   logic [`CORE_XLEN-1:0]  mem_result, mem_store;
   logic [`CORE_RADDR-1:0] mem_rd;
   logic                   mem_we;
   load_op_e               mem_load_op;
   store_op_e              mem_store_op;
   // register file write port
   logic [`CORE_RADDR-1:0] wb_rd;
   logic [`CORE_XLEN-1:0]  wb_data;
   logic                   wb_we_rf;

   fetch_stage fetch_stage_i (.*);

   // decode's wb_we is the register write, not the bus write
   decode_stage decode_stage_i (.*, .wb_we(wb_we_rf));

   execute_stage execute_stage_i (.*);

   memory_stage memory_stage_i (.*, .mem_wait(freeze));

endmodule

// ==== hw/memory_stage.sv ====
/*
 * memory stage
 * Wishbone classic master for loads and stores with byte lane steering,
 * load extraction and the writeback register feeding the register file
 */
`timescale 1ns/100ps
`include "core_params.svh"

module memory_stage import core_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_b,
   input  logic [`CORE_XLEN-1:0]  mem_result,
   input  logic [`CORE_XLEN-1:0]  mem_store,
   input  logic [`CORE_RADDR-1:0] mem_rd,
   input  logic                   mem_we,
   input  load_op_e               mem_load_op,
   input  store_op_e              mem_store_op,
   output logic                   wb_cyc,
   output logic                   wb_stb,
   output logic                   wb_we,
   output logic [29:0]            wb_adr,
   output logic [`CORE_SEL_W-1:0] wb_sel,
   output logic [`CORE_XLEN-1:0]  wb_dat_w,
   input  logic [`CORE_XLEN-1:0]  wb_dat_r,
   input  logic                   wb_ack,
   output logic                   mem_wait,
   output logic [`CORE_RADDR-1:0] wb_rd,
   output logic [`CORE_XLEN-1:0]  wb_data,
   output logic                   wb_we_rf
);

   logic [1:0]            off;
   logic [4:0]            lane_shift;
   logic                  is_load;
   logic [`CORE_XLEN-1:0] lane_data, wb_next;

   assign off        = mem_result[1:0];
   assign lane_shift = {off, 3'b000};
   assign is_load    = mem_load_op inside {LD_LB, LD_LH, LD_LW, LD_LBU, LD_LHU};

   // one bus cycle per load or store, held by the freeze until ack
   assign wb_cyc   = is_load || mem_store_op != ST_NONE;
   assign wb_stb   = wb_cyc;
   assign wb_we    = mem_store_op != ST_NONE;
   assign wb_adr   = mem_result[31:2];
   assign mem_wait = wb_stb && !wb_ack;

   // byte lanes follow the low address bits
   always_comb begin
      case (mem_store_op)
         ST_SB:   wb_dat_w = {24'h0, mem_store[7:0]} << lane_shift;
         ST_SH:   wb_dat_w = {16'h0, mem_store[15:0]} << lane_shift;
         default: wb_dat_w = mem_store;
      endcase
      if (mem_store_op == ST_SB || mem_load_op inside {LD_LB, LD_LBU})
         wb_sel = 4'b0001 << off;
      else if (mem_store_op == ST_SH || mem_load_op inside {LD_LH, LD_LHU})
         wb_sel = 4'b0011 << off;
      else if (wb_cyc)
         wb_sel = 4'b1111;
      else
         wb_sel = 4'b0000;
   end

   assign lane_data = wb_dat_r >> lane_shift;

   always_comb begin
      case (mem_load_op)
         LD_LB:   wb_next = {{24{lane_data[7]}}, lane_data[7:0]};
         LD_LH:   wb_next = {{16{lane_data[15]}}, lane_data[15:0]};
         LD_LBU:  wb_next = {24'h0, lane_data[7:0]};
         LD_LHU:  wb_next = {16'h0, lane_data[15:0]};
         LD_LW:   wb_next = wb_dat_r;
         // ALU results and lui pass straight through
         default: wb_next = mem_result;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb_we_rf <= 1'b0;
         wb_rd    <= '0;
      end else if (!mem_wait) begin
         wb_we_rf <= mem_we;
         wb_rd    <= mem_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (!mem_wait)
         wb_data <= wb_next;
   end

   // request stays on the bus unchanged until the slave acks
   assert property (@(posedge clk) disable iff (!rst_b)
      (wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we)
                               && $stable(wb_sel) && $stable(wb_dat_w)));

   // halfword and word accesses stay inside one aligned word
   assert property (@(posedge clk) disable iff (!rst_b)
      wb_stb |-> (!(off[0] && (mem_store_op inside {ST_SH, ST_SW} ||
                               mem_load_op inside {LD_LH, LD_LHU, LD_LW})) &&
                  !(off[1] && (mem_store_op == ST_SW || mem_load_op == LD_LW))));

endmodule

// ==== hw/execute_stage.sv ====
/*
 * execute stage
 * picks the ALU operands, runs the sixteen ALU operations and the
 * address add, then loads the execute/memory register
 */
`timescale 1ns/100ps
`include "core_params.svh"

module execute_stage import core_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_b,
   input  logic                   freeze,
   input  logic [`CORE_XLEN-1:0]  ex_a,
   input  logic [`CORE_XLEN-1:0]  ex_b,
   input  logic [`CORE_XLEN-1:0]  ex_imm,
   input  logic [`CORE_RADDR-1:0] ex_rd,
   input  logic                   ex_we,
   input  alu_op_e                ex_alu_op,
   input  load_op_e               ex_load_op,
   input  store_op_e              ex_store_op,
   output logic [`CORE_XLEN-1:0]  mem_result,
   output logic [`CORE_XLEN-1:0]  mem_store,
   output logic [`CORE_RADDR-1:0] mem_rd,
   output logic                   mem_we,
   output load_op_e               mem_load_op,
   output store_op_e              mem_store_op
);

   logic [`CORE_XLEN-1:0] op_b, alu_out;
   logic [4:0]            shamt;
   logic                  mem_ref;

   // memory ops add the offset, ex_b keeps the store data
   assign mem_ref = ex_load_op != LD_NONE || ex_store_op != ST_NONE;
   assign op_b    = mem_ref ? ex_imm : ex_b;
   // constant shifts use shamt, variable shifts use rs
   assign shamt   = (ex_alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA}) ? ex_imm[4:0] : ex_a[4:0];

   always_comb begin
      case (ex_alu_op)
         ALU_ADD, ALU_ADDU: alu_out = ex_a + op_b;
         ALU_SUB, ALU_SUBU: alu_out = ex_a - op_b;
         ALU_AND:           alu_out = ex_a & op_b;
         ALU_OR:            alu_out = ex_a | op_b;
         ALU_XOR:           alu_out = ex_a ^ op_b;
         ALU_NOR:           alu_out = ~(ex_a | op_b);
         ALU_SLT:           alu_out = {31'h0, $signed(ex_a) < $signed(op_b)};
         ALU_SLTU:          alu_out = {31'h0, ex_a < op_b};
         ALU_SLL, ALU_SLLV: alu_out = op_b << shamt;
         ALU_SRL, ALU_SRLV: alu_out = op_b >> shamt;
         // sra and srav
         default:           alu_out = $signed(op_b) >>> shamt;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         mem_rd       <= '0;
         mem_we       <= 1'b0;
         mem_load_op  <= LD_NONE;
         mem_store_op <= ST_NONE;
      end else if (!freeze) begin
         mem_rd       <= ex_rd;
         mem_we       <= ex_we;
         mem_load_op  <= ex_load_op;
         mem_store_op <= ex_store_op;
      end
   end

   always_ff @(posedge clk) begin
      if (!freeze) begin
         // lui leaves here already in the upper half
         mem_result <= (ex_load_op == LD_LUI) ? {ex_imm[15:0], 16'h0} : alu_out;
         mem_store  <= ex_b;
      end
   end

endmodule

// ==== hw/decode_stage.sv ====
/*
 * decode stage
 * decodes through both instruction views, reads the register file and
 * interlocks on RAW hazards against execute and memory; writeback hits
 * are served by the same-cycle bypass of the register file
 */
`timescale 1ns/100ps
`include "core_params.svh"

module decode_stage import core_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_b,
   input  logic                   freeze,
   input  instr_u                 id_inst,
   input  logic                   id_valid,
   input  logic                   wb_we,
   input  logic [`CORE_RADDR-1:0] wb_rd,
   input  logic [`CORE_XLEN-1:0]  wb_data,
   output logic                   hazard_stall,
   output logic [`CORE_XLEN-1:0]  ex_a,
   output logic [`CORE_XLEN-1:0]  ex_b,
   output logic [`CORE_XLEN-1:0]  ex_imm,
   output logic [`CORE_RADDR-1:0] ex_rd,
   output logic                   ex_we,
   output alu_op_e                ex_alu_op,
   output load_op_e               ex_load_op,
   output store_op_e              ex_store_op,
   input  logic [`CORE_RADDR-1:0] mem_rd,
   input  logic                   mem_we
);

   logic [`CORE_XLEN-1:0]  regs [1:31];
   logic [`CORE_XLEN-1:0]  rs_val, rt_val, imm, b_val;
   logic [`CORE_RADDR-1:0] rs, rt, dest;
   logic                   we, uses_rt, zext_op, issue;
   alu_op_e                alu_op;
   load_op_e               load_op;
   store_op_e              store_op;

   assign rs = id_inst.i.rs;
   assign rt = id_inst.i.rt;

   // logical immediates and lui are zero extended
   assign zext_op = id_inst.i.op inside {`CORE_OP_ANDI, `CORE_OP_ORI, `CORE_OP_XORI,
                                         `CORE_OP_LUI};

   // r0 reads zero, a write in this cycle is seen at once
   assign rs_val = (rs == '0) ? '0 : (wb_we && wb_rd == rs) ? wb_data : regs[rs];
   assign rt_val = (rt == '0) ? '0 : (wb_we && wb_rd == rt) ? wb_data : regs[rt];

   always_ff @(posedge clk) begin
      if (wb_we && wb_rd != '0)
         regs[wb_rd] <= wb_data;
   end

   always_comb begin
      alu_op   = ALU_ADDU;
      load_op  = LD_NONE;
      store_op = ST_NONE;
      dest     = rt;
      we       = 1'b1;
      imm      = zext_op ? {16'h0, id_inst.i.imm} : {{16{id_inst.i.imm[15]}}, id_inst.i.imm};
      case (id_inst.i.op)
         `CORE_OP_SPECIAL: begin
            dest = id_inst.r.rd;
            // shamt goes down in the immediate
            imm  = {27'h0, id_inst.r.shamt};
            case (id_inst.r.funct)
               `CORE_FN_SLL:  alu_op = ALU_SLL;
               `CORE_FN_SRL:  alu_op = ALU_SRL;
               `CORE_FN_SRA:  alu_op = ALU_SRA;
               `CORE_FN_SLLV: alu_op = ALU_SLLV;
               `CORE_FN_SRLV: alu_op = ALU_SRLV;
               `CORE_FN_SRAV: alu_op = ALU_SRAV;
               `CORE_FN_ADD:  alu_op = ALU_ADD;
               `CORE_FN_ADDU: alu_op = ALU_ADDU;
               `CORE_FN_SUB:  alu_op = ALU_SUB;
               `CORE_FN_SUBU: alu_op = ALU_SUBU;
               `CORE_FN_AND:  alu_op = ALU_AND;
               `CORE_FN_OR:   alu_op = ALU_OR;
               `CORE_FN_XOR:  alu_op = ALU_XOR;
               `CORE_FN_NOR:  alu_op = ALU_NOR;
               `CORE_FN_SLT:  alu_op = ALU_SLT;
               `CORE_FN_SLTU: alu_op = ALU_SLTU;
               default:       we = 1'b0;
            endcase
         end
         `CORE_OP_ADDI:  alu_op = ALU_ADD;
         `CORE_OP_ADDIU: alu_op = ALU_ADDU;
         `CORE_OP_SLTI:  alu_op = ALU_SLT;
         `CORE_OP_SLTIU: alu_op = ALU_SLTU;
         `CORE_OP_ANDI:  alu_op = ALU_AND;
         `CORE_OP_ORI:   alu_op = ALU_OR;
         `CORE_OP_XORI:  alu_op = ALU_XOR;
         `CORE_OP_LUI:   load_op = LD_LUI;
         `CORE_OP_LB:    load_op = LD_LB;
         `CORE_OP_LH:    load_op = LD_LH;
         `CORE_OP_LW:    load_op = LD_LW;
         `CORE_OP_LBU:   load_op = LD_LBU;
         `CORE_OP_LHU:   load_op = LD_LHU;
         `CORE_OP_SB:    store_op = ST_SB;
         `CORE_OP_SH:    store_op = ST_SH;
         `CORE_OP_SW:    store_op = ST_SW;
         default:        we = 1'b0;
      endcase
      // stores and r0 targets never write
      if (store_op != ST_NONE || dest == '0)
         we = 1'b0;
   end

   // rt is a source only for R-type and stores
   assign uses_rt = id_inst.i.op == `CORE_OP_SPECIAL || store_op != ST_NONE;
   // I-type ALU ops have no rt source so the immediate takes its slot
   assign b_val   = uses_rt ? rt_val : imm;

   // pending writes in execute or memory block the read
   assign hazard_stall = id_valid &&
      ((rs != '0 && ((ex_we && ex_rd == rs) || (mem_we && mem_rd == rs))) ||
       (uses_rt && rt != '0 && ((ex_we && ex_rd == rt) || (mem_we && mem_rd == rt))));
   assign issue = id_valid && !hazard_stall;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_rd       <= '0;
         ex_we       <= 1'b0;
         ex_alu_op   <= ALU_ADDU;
         ex_load_op  <= LD_NONE;
         ex_store_op <= ST_NONE;
      end else if (!freeze) begin
         ex_rd       <= dest;
         ex_alu_op   <= alu_op;
         // stalled or empty slot leaves as a bubble
         ex_we       <= issue && we;
         ex_load_op  <= issue ? load_op : LD_NONE;
         ex_store_op <= issue ? store_op : ST_NONE;
      end
   end

   always_ff @(posedge clk) begin
      if (!freeze) begin
         ex_a   <= rs_val;
         ex_b   <= b_val;
         ex_imm <= imm;
      end
   end

   // two unfrozen stall cycles push every producer past memory
   assert property (@(posedge clk) disable iff (!rst_b)
      (hazard_stall && !freeze && $past(hazard_stall && !freeze)) |=> !hazard_stall);

endmodule

// ==== hw/fetch_stage.sv ====
/*
 * fetch stage
 * holds the pc and the fetch/decode register, steps one word per cycle
 * unless the pipe is frozen or decode stalls on a hazard
 */
`timescale 1ns/100ps
`include "core_params.svh"

module fetch_stage import core_pkg::*; (
   input  logic        clk,
   input  logic        rst_b,
   input  logic        freeze,
   input  logic        hazard_stall,
   input  logic [31:0] inst,
   output logic [29:0] inst_addr,
   output instr_u      id_inst,
   output logic        id_valid
);

   logic advance;

   // both stall sources hold pc and decode register alike
   assign advance = !freeze && !hazard_stall;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         inst_addr <= 30'(`CORE_TEXT_START >> 2);
         // all-zero word is sll r0,r0,0
         id_inst   <= '0;
         id_valid  <= 1'b0;
      end else if (advance) begin
         inst_addr <= inst_addr + 30'd1;
         id_inst   <= inst;
         id_valid  <= 1'b1;
      end
   end

   // held cycle refetches the same word
   assert property (@(posedge clk) disable iff (!rst_b)
      !advance |=> $stable(inst));

endmodule

// ==== hw/core_pkg.sv ====
/*
 * shared types of the pipeline
 * the instruction word with its R and I views and the operation codes
 * that travel down the stages
 */
`include "core_params.svh"

package core_pkg;

   // R format view
   typedef struct packed {
      logic [5:0]             op;
      logic [`CORE_RADDR-1:0] rs;
      logic [`CORE_RADDR-1:0] rt;
      logic [`CORE_RADDR-1:0] rd;
      logic [4:0]             shamt;
      logic [5:0]             funct;
   } r_fmt_t;

   // I format view with the immediate in the low half
   typedef struct packed {
      logic [5:0]             op;
      logic [`CORE_RADDR-1:0] rs;
      logic [`CORE_RADDR-1:0] rt;
      logic [15:0]            imm;
   } i_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV
   } alu_op_e;

   // lui rides with the loads since it also picks the writeback value
   typedef enum logic [2:0] {
      LD_NONE, LD_LB, LD_LH, LD_LW, LD_LBU, LD_LHU, LD_LUI
   } load_op_e;

   typedef enum logic [1:0] {ST_NONE, ST_SB, ST_SH, ST_SW} store_op_e;

endpackage

// ==== hw/core_params.svh ====
/*
 * configuration macros for the four-stage MIPS-I subset core
 * datapath widths, the reset pc and the opcode and funct encodings
 */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data word, register index and byte select widths
`define CORE_XLEN        32
`define CORE_RADDR       5
`define CORE_SEL_W       4
// byte address of the first fetch after reset
`define CORE_TEXT_START  32'h0040_0000

// primary opcodes
`define CORE_OP_SPECIAL  6'h00
`define CORE_OP_ADDI     6'h08
`define CORE_OP_ADDIU    6'h09
`define CORE_OP_SLTI     6'h0a
`define CORE_OP_SLTIU    6'h0b
`define CORE_OP_ANDI     6'h0c
`define CORE_OP_ORI      6'h0d
`define CORE_OP_XORI     6'h0e
`define CORE_OP_LUI      6'h0f
`define CORE_OP_LB       6'h20
`define CORE_OP_LH       6'h21
`define CORE_OP_LW       6'h23
`define CORE_OP_LBU      6'h24
`define CORE_OP_LHU      6'h25
`define CORE_OP_SB       6'h28
`define CORE_OP_SH       6'h29
`define CORE_OP_SW       6'h2b

// funct field of SPECIAL
`define CORE_FN_SLL      6'h00
`define CORE_FN_SRL      6'h02
`define CORE_FN_SRA      6'h03
`define CORE_FN_SLLV     6'h04
`define CORE_FN_SRLV     6'h06
`define CORE_FN_SRAV     6'h07
`define CORE_FN_ADD      6'h20
`define CORE_FN_ADDU     6'h21
`define CORE_FN_SUB      6'h22
`define CORE_FN_SUBU     6'h23
`define CORE_FN_AND      6'h24
`define CORE_FN_OR       6'h25
`define CORE_FN_XOR      6'h26
`define CORE_FN_NOR      6'h27
`define CORE_FN_SLT      6'h2a
`define CORE_FN_SLTU     6'h2b

`endif
